// ==== src/or_ctrl_macros.svh ====
`ifndef OR_CTRL_MACROS_SVH
`define OR_CTRL_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// instruction word geometry
//////////////////////////////////////////////////////////////////////

`define OR_CTRL_INSN_W 32

// major opcode sits in the top six bits
`define OR_CTRL_OPC_W 6
`define OR_CTRL_OPC_LSB 26

// register fields: rd at 25:21, ra at 20:16, rb at 15:11
`define OR_CTRL_REG_W 5
`define OR_CTRL_RD_LSB 21
`define OR_CTRL_RA_LSB 16
`define OR_CTRL_RB_LSB 11

// immediate and compare code fields
`define OR_CTRL_IMM_W 16
`define OR_CTRL_COMP_W 4

//////////////////////////////////////////////////////////////////////
// fixed values
//////////////////////////////////////////////////////////////////////

// r9 takes the return address of jump-and-link
`define OR_CTRL_LINK_REG 9

// l.nop with bit 16 set marks a bubble
`define OR_CTRL_NOP_WORD 32'h1541_0000

`endif

// ==== src/or_ctrl_pkg.sv ====
`default_nettype none

`include "or_ctrl_macros.svh"

package or_ctrl_pkg;

	//////////////////////////////////////////////////////////////////////
	// major opcodes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [`OR_CTRL_OPC_W-1:0] {
		OPC_J     = 6'h00,
		OPC_JAL   = 6'h01,
		OPC_BNF   = 6'h03,
		OPC_BF    = 6'h04,
		OPC_NOP   = 6'h05,
		OPC_MOVHI = 6'h06,
		OPC_XSYNC = 6'h08,
		OPC_RFE   = 6'h09,
		OPC_JR    = 6'h11,
		OPC_JALR  = 6'h12,
		OPC_LWZ   = 6'h21,
		OPC_LWS   = 6'h22,
		OPC_LBZ   = 6'h23,
		OPC_LBS   = 6'h24,
		OPC_LHZ   = 6'h25,
		OPC_LHS   = 6'h26,
		OPC_ADDI  = 6'h27,
		OPC_ADDIC = 6'h28,
		OPC_ANDI  = 6'h29,
		OPC_ORI   = 6'h2a,
		OPC_XORI  = 6'h2b,
		OPC_MFSPR = 6'h2d,
		OPC_SFXXI = 6'h2f,
		OPC_MTSPR = 6'h30,
		OPC_SW    = 6'h35,
		OPC_SB    = 6'h36,
		OPC_SH    = 6'h37,
		OPC_ALU   = 6'h38,
		OPC_SFXX  = 6'h39
	} opcode_t;

	//////////////////////////////////////////////////////////////////////
	// execute control encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		ALU_ADD   = 5'd0,
		ALU_ADDC  = 5'd1,
		ALU_SUB   = 5'd2,
		ALU_AND   = 5'd3,
		ALU_OR    = 5'd4,
		ALU_XOR   = 5'd5,
		ALU_MUL   = 5'd6,
		ALU_SHROT = 5'd8,
		ALU_DIV   = 5'd9,
		ALU_DIVU  = 5'd10,
		ALU_COMP  = 5'd13,
		ALU_MOVHI = 5'd15
	} alu_op_t;

	// no-op is an OR, which leaves the operand untouched
	localparam alu_op_t ALU_NOP = ALU_OR;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0,
		BR_J   = 3'd1,
		BR_JR  = 3'd2,
		BR_BNF = 3'd3,
		BR_BF  = 3'd4,
		BR_RFE = 3'd6
	} branch_op_t;

	typedef enum logic [2:0] {
		RFWB_ALU  = 3'd0,
		RFWB_LSU  = 3'd1,
		RFWB_SPRS = 3'd2,
		RFWB_LR   = 3'd3
	} rfwb_src_t;

	// write enable in bit 0, source above it
	typedef struct packed {
		rfwb_src_t src;
		logic      we;
	} rfwb_op_t;

	localparam rfwb_op_t RFWB_OP_NOP = '0;

	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_t;

endpackage

`default_nettype wire

// ==== src/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "or_ctrl_macros.svh"

module id_stage (
	input  wire                            clk,
	input  wire                            rst,
	input  wire [`OR_CTRL_INSN_W-1:0]      if_insn,
	input  wire                            id_freeze,
	input  wire                            except_flushpipe,
	input  wire                            pc_we,
	input  wire                            extend_flush,
	output logic                           flushpipe,
	output logic [`OR_CTRL_INSN_W-1:0]     id_insn,
	output or_ctrl_pkg::branch_op_t        id_branch_op,
	output logic                           sel_imm,
	output logic [`OR_CTRL_REG_W-1:0]      rf_addra,
	output logic [`OR_CTRL_REG_W-1:0]      rf_addrb,
	output logic                           rf_rda,
	output logic                           rf_rdb
);

	or_ctrl_pkg::opcode_t    if_opc;
	or_ctrl_pkg::branch_op_t if_branch_op;
	logic                    if_sel_imm;

	// any of the three causes empties the front of the pipe
	assign flushpipe = except_flushpipe | pc_we | extend_flush;

	// register file read ports come straight from fetch
	assign rf_addra = if_insn[`OR_CTRL_RA_LSB +: `OR_CTRL_REG_W];
	assign rf_addrb = if_insn[`OR_CTRL_RB_LSB +: `OR_CTRL_REG_W];
	assign rf_rda   = if_insn[31];
	assign rf_rdb   = if_insn[30];

	//////////////////////////////////////////////////////////////////////
	// predecode of the fetched word
	//////////////////////////////////////////////////////////////////////

	assign if_opc = or_ctrl_pkg::opcode_t'(if_insn[`OR_CTRL_INSN_W-1:`OR_CTRL_OPC_LSB]);

	always_comb begin
		if_branch_op = or_ctrl_pkg::BR_NOP;
		if_sel_imm   = 1'b1;
		case (if_opc)
			or_ctrl_pkg::OPC_J, or_ctrl_pkg::OPC_JAL: if_branch_op = or_ctrl_pkg::BR_J;
			or_ctrl_pkg::OPC_BNF: if_branch_op = or_ctrl_pkg::BR_BNF;
			or_ctrl_pkg::OPC_BF:  if_branch_op = or_ctrl_pkg::BR_BF;
			or_ctrl_pkg::OPC_JR, or_ctrl_pkg::OPC_JALR: begin
				if_branch_op = or_ctrl_pkg::BR_JR;
				if_sel_imm   = 1'b0;
			end
			or_ctrl_pkg::OPC_RFE: begin
				if_branch_op = or_ctrl_pkg::BR_RFE;
				if_sel_imm   = 1'b0;
			end
			// register-register forms and words without an operand immediate
			or_ctrl_pkg::OPC_MFSPR, or_ctrl_pkg::OPC_MTSPR, or_ctrl_pkg::OPC_XSYNC,
			or_ctrl_pkg::OPC_SW, or_ctrl_pkg::OPC_SB, or_ctrl_pkg::OPC_SH,
			or_ctrl_pkg::OPC_ALU, or_ctrl_pkg::OPC_SFXX, or_ctrl_pkg::OPC_NOP:
				if_sel_imm = 1'b0;
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// decode stage registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || flushpipe) begin
			id_insn      <= `OR_CTRL_NOP_WORD;
			id_branch_op <= or_ctrl_pkg::BR_NOP;
		end else if (!id_freeze) begin
			id_insn      <= if_insn;
			id_branch_op <= if_branch_op;
		end
	end

	// operand select does not see the flush
	always_ff @(posedge clk) begin
		if (rst)
			sel_imm <= 1'b0;
		else if (!id_freeze)
			sel_imm <= if_sel_imm;
	end

endmodule

`default_nettype wire

// ==== src/ex_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "or_ctrl_macros.svh"

module ex_decode (
	input  wire                               clk,
	input  wire                               rst,
	input  wire [`OR_CTRL_INSN_W-1:0]         id_insn,
	input  or_ctrl_pkg::branch_op_t           id_branch_op,
	input  wire                               id_freeze,
	input  wire                               ex_freeze,
	input  wire                               flushpipe,
	output logic [`OR_CTRL_INSN_W-1:0]        id_simm,
	output logic [`OR_CTRL_INSN_W-1:0]        ex_simm,
	output logic [`OR_CTRL_INSN_W-1:0]        ex_insn,
	output or_ctrl_pkg::branch_op_t           ex_branch_op,
	output or_ctrl_pkg::alu_op_t              alu_op,
	output logic [`OR_CTRL_COMP_W-1:0]        comp_op,
	output or_ctrl_pkg::rfwb_op_t             rfwb_op,
	output logic [`OR_CTRL_REG_W-1:0]         rf_addrw,
	output logic                              spr_read,
	output logic                              spr_write,
	output logic                              sig_syscall,
	output logic                              sig_trap,
	output logic                              except_illegal
);

	localparam int EXT_W = `OR_CTRL_INSN_W - `OR_CTRL_IMM_W;
	localparam logic [`OR_CTRL_REG_W-1:0] LINK_REG = `OR_CTRL_LINK_REG;

	or_ctrl_pkg::opcode_t  id_opc;
	or_ctrl_pkg::alu_op_t  id_alu_op;
	or_ctrl_pkg::rfwb_op_t id_rfwb_op;
	logic [`OR_CTRL_REG_W-1:0] id_rf_addrw;
	logic [`OR_CTRL_IMM_W-1:0] split_imm;
	logic id_illegal;
	logic bubble;

	assign id_opc = or_ctrl_pkg::opcode_t'(id_insn[`OR_CTRL_INSN_W-1:`OR_CTRL_OPC_LSB]);

	// execute takes a NOP while decode is frozen or the pipe is flushed
	assign bubble = !ex_freeze && (id_freeze || flushpipe);

	// store and mtspr offsets are split around the rb field
	assign split_imm = {id_insn[25:21], id_insn[10:0]};

	//////////////////////////////////////////////////////////////////////
	// immediate extension
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (id_opc)
			or_ctrl_pkg::OPC_ADDI, or_ctrl_pkg::OPC_ADDIC, or_ctrl_pkg::OPC_XORI,
			or_ctrl_pkg::OPC_SFXXI, or_ctrl_pkg::OPC_LWZ, or_ctrl_pkg::OPC_LWS,
			or_ctrl_pkg::OPC_LBZ, or_ctrl_pkg::OPC_LBS, or_ctrl_pkg::OPC_LHZ,
			or_ctrl_pkg::OPC_LHS:
				id_simm = {{EXT_W{id_insn[15]}}, id_insn[15:0]};
			or_ctrl_pkg::OPC_SW, or_ctrl_pkg::OPC_SB, or_ctrl_pkg::OPC_SH:
				id_simm = {{EXT_W{split_imm[15]}}, split_imm};
			or_ctrl_pkg::OPC_MTSPR:
				id_simm = {{EXT_W{1'b0}}, split_imm};
			default:
				id_simm = {{EXT_W{1'b0}}, id_insn[15:0]};
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// control decode of the decode-stage word
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		id_alu_op   = or_ctrl_pkg::ALU_NOP;
		id_rfwb_op  = or_ctrl_pkg::RFWB_OP_NOP;
		id_rf_addrw = id_insn[`OR_CTRL_RD_LSB +: `OR_CTRL_REG_W];
		id_illegal  = 1'b0;
		case (id_opc)
			or_ctrl_pkg::OPC_JAL, or_ctrl_pkg::OPC_JALR: begin
				id_rfwb_op  = '{src: or_ctrl_pkg::RFWB_LR, we: 1'b1};
				id_rf_addrw = LINK_REG;
			end
			or_ctrl_pkg::OPC_MFSPR: id_rfwb_op = '{src: or_ctrl_pkg::RFWB_SPRS, we: 1'b1};
			or_ctrl_pkg::OPC_LWZ, or_ctrl_pkg::OPC_LWS, or_ctrl_pkg::OPC_LBZ,
			or_ctrl_pkg::OPC_LBS, or_ctrl_pkg::OPC_LHZ, or_ctrl_pkg::OPC_LHS:
				id_rfwb_op = '{src: or_ctrl_pkg::RFWB_LSU, we: 1'b1};
			or_ctrl_pkg::OPC_MOVHI: begin
				id_alu_op  = or_ctrl_pkg::ALU_MOVHI;
				id_rfwb_op = '{src: or_ctrl_pkg::RFWB_ALU, we: 1'b1};
			end
			or_ctrl_pkg::OPC_ADDI: begin
				id_alu_op  = or_ctrl_pkg::ALU_ADD;
				id_rfwb_op = '{src: or_ctrl_pkg::RFWB_ALU, we: 1'b1};
			end
			or_ctrl_pkg::OPC_ADDIC: begin
				id_alu_op  = or_ctrl_pkg::ALU_ADDC;
				id_rfwb_op = '{src: or_ctrl_pkg::RFWB_ALU, we: 1'b1};
			end
			or_ctrl_pkg::OPC_ANDI: begin
				id_alu_op  = or_ctrl_pkg::ALU_AND;
				id_rfwb_op = '{src: or_ctrl_pkg::RFWB_ALU, we: 1'b1};
			end
			or_ctrl_pkg::OPC_ORI: begin
				id_alu_op  = or_ctrl_pkg::ALU_OR;
				id_rfwb_op = '{src: or_ctrl_pkg::RFWB_ALU, we: 1'b1};
			end
			or_ctrl_pkg::OPC_XORI: begin
				id_alu_op  = or_ctrl_pkg::ALU_XOR;
				id_rfwb_op = '{src: or_ctrl_pkg::RFWB_ALU, we: 1'b1};
			end
			or_ctrl_pkg::OPC_ALU: begin
				// low nibble carries the operation, divides are not built
				id_alu_op  = or_ctrl_pkg::alu_op_t'({1'b0, id_insn[3:0]});
				id_rfwb_op = '{src: or_ctrl_pkg::RFWB_ALU, we: 1'b1};
				id_illegal = (id_insn[4:0] == or_ctrl_pkg::ALU_DIV) ||
					(id_insn[4:0] == or_ctrl_pkg::ALU_DIVU);
			end
			or_ctrl_pkg::OPC_SFXX, or_ctrl_pkg::OPC_SFXXI: id_alu_op = or_ctrl_pkg::ALU_COMP;
			or_ctrl_pkg::OPC_J, or_ctrl_pkg::OPC_BNF, or_ctrl_pkg::OPC_BF,
			or_ctrl_pkg::OPC_NOP, or_ctrl_pkg::OPC_XSYNC, or_ctrl_pkg::OPC_RFE,
			or_ctrl_pkg::OPC_JR, or_ctrl_pkg::OPC_MTSPR, or_ctrl_pkg::OPC_SW,
			or_ctrl_pkg::OPC_SB, or_ctrl_pkg::OPC_SH: ;
			// unknown opcode
			default: id_illegal = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// execute stage registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			ex_insn        <= `OR_CTRL_NOP_WORD;
			ex_branch_op   <= or_ctrl_pkg::BR_NOP;
			alu_op         <= or_ctrl_pkg::ALU_NOP;
			comp_op        <= '0;
			rfwb_op        <= or_ctrl_pkg::RFWB_OP_NOP;
			rf_addrw       <= '0;
			spr_read       <= 1'b0;
			spr_write      <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
			except_illegal <= 1'b0;
		end else if (!ex_freeze) begin
			ex_insn        <= id_insn;
			ex_branch_op   <= id_branch_op;
			alu_op         <= id_alu_op;
			comp_op        <= id_insn[`OR_CTRL_RD_LSB +: `OR_CTRL_COMP_W];
			rfwb_op        <= id_rfwb_op;
			rf_addrw       <= id_rf_addrw;
			spr_read       <= (id_opc == or_ctrl_pkg::OPC_MFSPR);
			spr_write      <= (id_opc == or_ctrl_pkg::OPC_MTSPR);
			sig_syscall    <= (id_insn[31:23] == {or_ctrl_pkg::OPC_XSYNC, 3'b000});
			sig_trap       <= (id_insn[31:23] == {or_ctrl_pkg::OPC_XSYNC, 3'b010});
			except_illegal <= id_illegal;
		end
	end

	// immediate follows the freeze only
	always_ff @(posedge clk) begin
		if (rst)
			ex_simm <= '0;
		else if (!ex_freeze)
			ex_simm <= id_simm;
	end

endmodule

`default_nettype wire

// ==== src/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "or_ctrl_macros.svh"

module operand_select (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          wb_freeze,
	input  wire [`OR_CTRL_INSN_W-1:0]    id_insn,
	input  wire                          sel_imm,
	input  wire [`OR_CTRL_REG_W-1:0]     rf_addrw,
	input  or_ctrl_pkg::rfwb_op_t        rfwb_op,
	input  wire [`OR_CTRL_INSN_W-1:0]    ex_insn,
	input  wire                          wbforw_valid,
	output logic [`OR_CTRL_INSN_W-1:0]   wb_insn,
	output or_ctrl_pkg::sel_t            sel_a,
	output or_ctrl_pkg::sel_t            sel_b
);

	logic [`OR_CTRL_REG_W-1:0] wb_rfaddrw;
	logic [`OR_CTRL_REG_W-1:0] id_ra;
	logic [`OR_CTRL_REG_W-1:0] id_rb;

	assign id_ra = id_insn[`OR_CTRL_RA_LSB +: `OR_CTRL_REG_W];
	assign id_rb = id_insn[`OR_CTRL_RB_LSB +: `OR_CTRL_REG_W];

	// write-back copy, kept for forwarding from the last stage
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_insn    <= `OR_CTRL_NOP_WORD;
			wb_rfaddrw <= '0;
		end else if (!wb_freeze) begin
			wb_insn    <= ex_insn;
			wb_rfaddrw <= rf_addrw;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// forwarding selects, newest result wins
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (id_ra == rf_addrw && rfwb_op.we)
			sel_a = or_ctrl_pkg::SEL_EX_FORW;
		else if (id_ra == wb_rfaddrw && wbforw_valid)
			sel_a = or_ctrl_pkg::SEL_WB_FORW;
		else
			sel_a = or_ctrl_pkg::SEL_RF;
	end

	// immediate overrides any forwarding on b
	always_comb begin
		if (sel_imm)
			sel_b = or_ctrl_pkg::SEL_IMM;
		else if (id_rb == rf_addrw && rfwb_op.we)
			sel_b = or_ctrl_pkg::SEL_EX_FORW;
		else if (id_rb == wb_rfaddrw && wbforw_valid)
			sel_b = or_ctrl_pkg::SEL_WB_FORW;
		else
			sel_b = or_ctrl_pkg::SEL_RF;
	end

endmodule

`default_nettype wire

// ==== src/or_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "or_ctrl_macros.svh"

module or_ctrl_top (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [`OR_CTRL_INSN_W-1:0]    if_insn,
	input  wire                          id_freeze,
	input  wire                          ex_freeze,
	input  wire                          wb_freeze,
	input  wire                          except_flushpipe,
	input  wire                          pc_we,
	input  wire                          extend_flush,
	input  wire                          wbforw_valid,
	output logic                         flushpipe,
	output logic [`OR_CTRL_INSN_W-1:0]   id_insn,
	output or_ctrl_pkg::branch_op_t      id_branch_op,
	output logic                         sel_imm,
	output logic [`OR_CTRL_REG_W-1:0]    rf_addra,
	output logic [`OR_CTRL_REG_W-1:0]    rf_addrb,
	output logic                         rf_rda,
	output logic                         rf_rdb,
	output logic [`OR_CTRL_INSN_W-1:0]   id_simm,
	output logic [`OR_CTRL_INSN_W-1:0]   ex_simm,
	output logic [`OR_CTRL_INSN_W-1:0]   ex_insn,
	output or_ctrl_pkg::branch_op_t      ex_branch_op,
	output or_ctrl_pkg::alu_op_t         alu_op,
	output logic [`OR_CTRL_COMP_W-1:0]   comp_op,
	output or_ctrl_pkg::rfwb_op_t        rfwb_op,
	output logic [`OR_CTRL_REG_W-1:0]    rf_addrw,
	output logic                         spr_read,
	output logic                         spr_write,
	output logic                         sig_syscall,
	output logic                         sig_trap,
	output logic                         except_illegal,
	output logic [`OR_CTRL_INSN_W-1:0]   wb_insn,
	output or_ctrl_pkg::sel_t            sel_a,
	output or_ctrl_pkg::sel_t            sel_b
);

	// decode stage latch and flush
	id_stage u_id_stage (.*);

	// execute stage latch and control decode
	ex_decode u_ex_decode (.*);

	// write-back copy and forwarding
	operand_select u_operand_select (.*);

endmodule

`default_nettype wire

// ==== sim/tb_or_ctrl_ref.svh ====
`ifndef TB_OR_CTRL_REF_SVH
`define TB_OR_CTRL_REF_SVH

//////////////////////////////////////////////////////////////////////
// expected decode of one instruction word
//////////////////////////////////////////////////////////////////////

// execute control vector, msb first:
// alu_op(5) comp_op(4) rfwb_op(4) rf_addrw(5) spr_read spr_write syscall trap illegal
localparam int DEC_W = 23;
localparam logic [DEC_W-1:0] DEC_BUBBLE = {or_ctrl_pkg::ALU_OR, 18'd0};

function automatic logic [2:0] ref_branch(input logic [31:0] insn);
	logic [5:0] opc;
	opc = insn[31:26];
	if (opc == or_ctrl_pkg::OPC_J || opc == or_ctrl_pkg::OPC_JAL)
		return or_ctrl_pkg::BR_J;
	if (opc == or_ctrl_pkg::OPC_JR || opc == or_ctrl_pkg::OPC_JALR)
		return or_ctrl_pkg::BR_JR;
	if (opc == or_ctrl_pkg::OPC_BNF)
		return or_ctrl_pkg::BR_BNF;
	if (opc == or_ctrl_pkg::OPC_BF)
		return or_ctrl_pkg::BR_BF;
	if (opc == or_ctrl_pkg::OPC_RFE)
		return or_ctrl_pkg::BR_RFE;
	return or_ctrl_pkg::BR_NOP;
endfunction

function automatic logic ref_sel_imm(input logic [31:0] insn);
	logic [5:0] opc;
	opc = insn[31:26];
	return !(opc inside {or_ctrl_pkg::OPC_JALR, or_ctrl_pkg::OPC_JR, or_ctrl_pkg::OPC_RFE,
		or_ctrl_pkg::OPC_MFSPR, or_ctrl_pkg::OPC_MTSPR, or_ctrl_pkg::OPC_XSYNC,
		or_ctrl_pkg::OPC_SW, or_ctrl_pkg::OPC_SB, or_ctrl_pkg::OPC_SH,
		or_ctrl_pkg::OPC_ALU, or_ctrl_pkg::OPC_SFXX, or_ctrl_pkg::OPC_NOP});
endfunction

function automatic logic [31:0] ref_simm(input logic [31:0] insn);
	logic [5:0] opc;
	logic [15:0] low;
	logic [15:0] split;
	opc = insn[31:26];
	low = insn[15:0];
	split = {insn[25:21], insn[10:0]};
	if (opc inside {or_ctrl_pkg::OPC_ADDI, or_ctrl_pkg::OPC_ADDIC, or_ctrl_pkg::OPC_XORI,
		or_ctrl_pkg::OPC_SFXXI, or_ctrl_pkg::OPC_LWZ, or_ctrl_pkg::OPC_LWS,
		or_ctrl_pkg::OPC_LBZ, or_ctrl_pkg::OPC_LBS, or_ctrl_pkg::OPC_LHZ,
		or_ctrl_pkg::OPC_LHS})
		return {{16{low[15]}}, low};
	if (opc inside {or_ctrl_pkg::OPC_SW, or_ctrl_pkg::OPC_SB, or_ctrl_pkg::OPC_SH})
		return {{16{split[15]}}, split};
	if (opc == or_ctrl_pkg::OPC_MTSPR)
		return {16'h0000, split};
	return {16'h0000, low};
endfunction

function automatic logic [DEC_W-1:0] ref_ex_decode(input logic [31:0] insn);
	logic [5:0] opc;
	logic [4:0] alu;
	logic [3:0] wb;
	logic [4:0] rd;
	logic listed;
	logic illegal;
	opc = insn[31:26];
	alu = or_ctrl_pkg::ALU_OR;
	wb = 4'h0;
	rd = insn[25:21];
	if (opc == or_ctrl_pkg::OPC_MOVHI) alu = or_ctrl_pkg::ALU_MOVHI;
	if (opc == or_ctrl_pkg::OPC_ADDI) alu = or_ctrl_pkg::ALU_ADD;
	if (opc == or_ctrl_pkg::OPC_ADDIC) alu = or_ctrl_pkg::ALU_ADDC;
	if (opc == or_ctrl_pkg::OPC_ANDI) alu = or_ctrl_pkg::ALU_AND;
	if (opc == or_ctrl_pkg::OPC_ORI) alu = or_ctrl_pkg::ALU_OR;
	if (opc == or_ctrl_pkg::OPC_XORI) alu = or_ctrl_pkg::ALU_XOR;
	if (opc == or_ctrl_pkg::OPC_SFXX || opc == or_ctrl_pkg::OPC_SFXXI)
		alu = or_ctrl_pkg::ALU_COMP;
	if (opc == or_ctrl_pkg::OPC_ALU) alu = {1'b0, insn[3:0]};
	// write-back source, then the enable bit
	if (opc == or_ctrl_pkg::OPC_JAL || opc == or_ctrl_pkg::OPC_JALR) begin
		wb = {or_ctrl_pkg::RFWB_LR, 1'b1};
		rd = 5'(`OR_CTRL_LINK_REG);
	end else if (opc == or_ctrl_pkg::OPC_MFSPR) begin
		wb = {or_ctrl_pkg::RFWB_SPRS, 1'b1};
	end else if (opc >= or_ctrl_pkg::OPC_LWZ && opc <= or_ctrl_pkg::OPC_LHS) begin
		wb = {or_ctrl_pkg::RFWB_LSU, 1'b1};
	end else if (opc inside {or_ctrl_pkg::OPC_MOVHI, or_ctrl_pkg::OPC_ADDI,
		or_ctrl_pkg::OPC_ADDIC, or_ctrl_pkg::OPC_ANDI, or_ctrl_pkg::OPC_ORI,
		or_ctrl_pkg::OPC_XORI, or_ctrl_pkg::OPC_ALU}) begin
		wb = {or_ctrl_pkg::RFWB_ALU, 1'b1};
	end
	listed = opc inside {6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h08, 6'h09,
		6'h11, 6'h12, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h28,
		6'h29, 6'h2a, 6'h2b, 6'h2d, 6'h2f, 6'h30, 6'h35, 6'h36, 6'h37, 6'h38, 6'h39};
	illegal = !listed || (opc == or_ctrl_pkg::OPC_ALU &&
		(insn[4:0] == 5'd9 || insn[4:0] == 5'd10));
	return {alu, insn[24:21], wb, rd,
		opc == or_ctrl_pkg::OPC_MFSPR, opc == or_ctrl_pkg::OPC_MTSPR,
		insn[31:23] == {or_ctrl_pkg::OPC_XSYNC, 3'b000},
		insn[31:23] == {or_ctrl_pkg::OPC_XSYNC, 3'b010}, illegal};
endfunction

// forwarding priority: execute result, then write-back, then the register file
function automatic logic [1:0] ref_forw_sel(input logic [4:0] src, input logic imm,
	input logic [4:0] ex_rd, input logic ex_we, input logic [4:0] wb_rd,
	input logic wb_valid);
	if (imm)
		return or_ctrl_pkg::SEL_IMM;
	if (src == ex_rd && ex_we)
		return or_ctrl_pkg::SEL_EX_FORW;
	if (src == wb_rd && wb_valid)
		return or_ctrl_pkg::SEL_WB_FORW;
	return or_ctrl_pkg::SEL_RF;
endfunction

`endif

// ==== sim/tb_or_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "or_ctrl_macros.svh"

module tb_or_ctrl;

	localparam int RESET_CYCLES = 16;
	localparam int STREAM_WORDS = 300;
	localparam int FORW_WORDS = 64;
	localparam int DRAIN = 4;
	localparam int TEST_CYCLES = 1 + (STREAM_WORDS + DRAIN + 1) + (9 + DRAIN + 1) +
		(24 + DRAIN + 1) + (FORW_WORDS + DRAIN + 1);
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + RESET_CYCLES;

	`include "tb_or_ctrl_ref.svh"

	logic clk;
	logic rst;
	logic [31:0] if_insn;
	logic id_freeze, ex_freeze, wb_freeze;
	logic except_flushpipe, pc_we, extend_flush;
	logic wbforw_valid;

	logic flushpipe;
	logic [31:0] id_insn, id_simm, ex_simm, ex_insn, wb_insn;
	or_ctrl_pkg::branch_op_t id_branch_op, ex_branch_op;
	logic sel_imm;
	logic [4:0] rf_addra, rf_addrb, rf_addrw;
	logic rf_rda, rf_rdb;
	or_ctrl_pkg::alu_op_t alu_op;
	logic [3:0] comp_op;
	or_ctrl_pkg::rfwb_op_t rfwb_op;
	logic spr_read, spr_write, sig_syscall, sig_trap, except_illegal;
	or_ctrl_pkg::sel_t sel_a, sel_b;
	logic [DEC_W-1:0] ex_dec_dut;

	// pipeline model with one entry per stage
	logic [31:0] m_id_insn, m_ex_insn, m_ex_simm, m_wb_insn;
	logic [2:0] m_id_br, m_ex_br;
	logic m_sel_imm;
	logic [DEC_W-1:0] m_ex_dec;
	logic [4:0] m_wb_rd;

	int error_count, check_count, tests_run, tests_failed, cycle_count;

	or_ctrl_top UUT (.*);

	assign ex_dec_dut = {alu_op, comp_op, rfwb_op, rf_addrw,
		spr_read, spr_write, sig_syscall, sig_trap, except_illegal};

	always #10 clk = ~clk;

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count != errors_before) begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, error_count - errors_before);
		end else begin
			$display("test %s done", name);
		end
	endtask

	// freeze bits are id ex wb and flush bits are except pc_we extend
	task automatic apply_cycle(input logic [31:0] insn, input logic [2:0] freeze,
		input logic [2:0] flush, input logic wfv);
		@(negedge clk);
		if_insn = insn;
		{id_freeze, ex_freeze, wb_freeze} = freeze;
		{except_flushpipe, pc_we, extend_flush} = flush;
		wbforw_valid = wfv;
	endtask

	task automatic drain_pipe();
		repeat (DRAIN) apply_cycle(`OR_CTRL_NOP_WORD, 3'b000, 3'b000, 1'b0);
		@(negedge clk);
	endtask

	// mostly listed opcodes with one word in eight from the whole opcode space
	function automatic logic [31:0] rand_word();
		or_ctrl_pkg::opcode_t opc;
		int unsigned k;
		logic [5:0] bits;
		logic [31:0] word;
		if ($urandom_range(7) == 0) begin
			bits = 6'($urandom);
		end else begin
			opc = opc.first();
			k = $urandom_range(opc.num() - 1);
			repeat (k) opc = opc.next();
			bits = opc;
		end
		word = {bits, 26'($urandom)};
		// divides and xsync sub-kinds would be rare otherwise
		if ($urandom_range(1) == 0) begin
			if (bits == or_ctrl_pkg::OPC_ALU)
				word[4:0] = 5'(9 + $urandom_range(1));
			if (bits == or_ctrl_pkg::OPC_XSYNC)
				word[25:23] = 3'(2 * $urandom_range(1));
		end
		return word;
	endfunction

	// registers r1 to r3 only so that dependencies are frequent
	function automatic logic [31:0] dep_word();
		logic [4:0] rd, ra, rb;
		rd = 5'(1 + $urandom_range(2));
		ra = 5'(1 + $urandom_range(2));
		rb = 5'(1 + $urandom_range(2));
		if ($urandom_range(1) == 0)
			return {or_ctrl_pkg::OPC_ALU, rd, ra, rb, 11'h000};
		return {or_ctrl_pkg::OPC_ADDI, rd, ra, rb, 11'($urandom)};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare against the model and then advance it
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : compare_pipeline
		logic flush;
		logic bubble;
		flush = except_flushpipe | pc_we | extend_flush;
		bubble = !ex_freeze && (id_freeze || flush);
		if (!rst) begin
			check_eq(32'(flushpipe), 32'(flush), "flushpipe");
			check_eq(32'({rf_addra, rf_addrb, rf_rda, rf_rdb}),
				32'({if_insn[20:16], if_insn[15:11], if_insn[31], if_insn[30]}), "read ports");
			check_eq(id_insn, m_id_insn, "id_insn");
			check_eq(32'(id_branch_op), 32'(m_id_br), "id_branch_op");
			check_eq(32'(sel_imm), 32'(m_sel_imm), "sel_imm");
			check_eq(id_simm, ref_simm(m_id_insn), $sformatf("id_simm of %h", m_id_insn));
			check_eq(ex_insn, m_ex_insn, "ex_insn");
			check_eq(32'(ex_branch_op), 32'(m_ex_br), "ex_branch_op");
			check_eq(32'(ex_dec_dut), 32'(m_ex_dec), $sformatf("ex decode of %h", m_ex_insn));
			check_eq(ex_simm, m_ex_simm, "ex_simm");
			check_eq(wb_insn, m_wb_insn, "wb_insn");
			check_eq(32'(sel_a), 32'(ref_forw_sel(m_id_insn[20:16], 1'b0, m_ex_dec[9:5],
				m_ex_dec[10], m_wb_rd, wbforw_valid)), "sel_a");
			check_eq(32'(sel_b), 32'(ref_forw_sel(m_id_insn[15:11], m_sel_imm, m_ex_dec[9:5],
				m_ex_dec[10], m_wb_rd, wbforw_valid)), "sel_b");
		end
		if (rst) begin
			m_id_insn = `OR_CTRL_NOP_WORD;
			m_id_br = or_ctrl_pkg::BR_NOP;
			m_sel_imm = 1'b0;
			m_ex_insn = `OR_CTRL_NOP_WORD;
			m_ex_br = or_ctrl_pkg::BR_NOP;
			m_ex_dec = DEC_BUBBLE;
			m_ex_simm = 32'h0;
			m_wb_insn = `OR_CTRL_NOP_WORD;
			m_wb_rd = 5'd0;
		end else begin
			// oldest stage first so each one reads the state before the edge
			if (!wb_freeze) begin
				m_wb_insn = m_ex_insn;
				m_wb_rd = m_ex_dec[9:5];
			end
			if (!ex_freeze)
				m_ex_simm = ref_simm(m_id_insn);
			if (bubble) begin
				m_ex_insn = `OR_CTRL_NOP_WORD;
				m_ex_br = or_ctrl_pkg::BR_NOP;
				m_ex_dec = DEC_BUBBLE;
			end else if (!ex_freeze) begin
				m_ex_insn = m_id_insn;
				m_ex_br = m_id_br;
				m_ex_dec = ref_ex_decode(m_id_insn);
			end
			if (!id_freeze)
				m_sel_imm = ref_sel_imm(if_insn);
			if (flush) begin
				m_id_insn = `OR_CTRL_NOP_WORD;
				m_id_br = or_ctrl_pkg::BR_NOP;
			end else if (!id_freeze) begin
				m_id_insn = if_insn;
				m_id_br = ref_branch(if_insn);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	initial begin
		int start;
		void'($urandom(32'h852));
		clk = 1'b0;
		rst = 1'b1;
		if_insn = `OR_CTRL_NOP_WORD;
		{id_freeze, ex_freeze, wb_freeze} = 3'b000;
		{except_flushpipe, pc_we, extend_flush} = 3'b000;
		wbforw_valid = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		start = error_count;
		check_eq(id_insn, `OR_CTRL_NOP_WORD, "id_insn after reset");
		check_eq(ex_insn, `OR_CTRL_NOP_WORD, "ex_insn after reset");
		check_eq(wb_insn, `OR_CTRL_NOP_WORD, "wb_insn after reset");
		check_eq(32'(ex_dec_dut), 32'(DEC_BUBBLE), "execute control after reset");
		check_eq(32'({id_branch_op, ex_branch_op, sel_imm}), 32'h0, "branch kinds after reset");
		check_eq(ex_simm, 32'h0, "ex_simm after reset");
		check_eq(32'(sel_a), 32'(or_ctrl_pkg::SEL_RF), "sel_a after reset");
		finish_test("reset", start);

		start = error_count;
		repeat (STREAM_WORDS) apply_cycle(rand_word(), 3'b000, 3'b000, 1'b0);
		drain_pipe();
		finish_test("decode_stream", start);

		start = error_count;
		for (int k = 0; k < 3; k++) begin
			apply_cycle(rand_word(), 3'b000, 3'b000, 1'b0);
			apply_cycle(rand_word(), 3'b000, 3'b100 >> k, 1'b0);
			apply_cycle(rand_word(), 3'b000, 3'b000, 1'b0);
		end
		drain_pipe();
		finish_test("flush", start);

		start = error_count;
		repeat (3) apply_cycle(rand_word(), 3'b000, 3'b000, 1'b0);
		repeat (6) apply_cycle(rand_word(), 3'b111, 3'b000, 1'b0);
		repeat (6) apply_cycle(rand_word(), 3'b100, 3'b000, 1'b0);
		repeat (9) apply_cycle(rand_word(), 3'b001, 3'b000, 1'b0);
		drain_pipe();
		finish_test("freeze", start);

		start = error_count;
		repeat (FORW_WORDS) apply_cycle(dep_word(), 3'b000, 3'b000, 1'($urandom_range(1)));
		drain_pipe();
		finish_test("forwarding", start);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
+incdir+sim
src/or_ctrl_pkg.sv
src/id_stage.sv
src/ex_decode.sv
src/operand_select.sv
src/or_ctrl_top.sv
sim/tb_or_ctrl.sv

// ==== Bender.yml ====
package:
  name: or_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/or_ctrl_pkg.sv
      - src/id_stage.sv
      - src/ex_decode.sv
      - src/operand_select.sv
      - src/or_ctrl_top.sv
  - target: simulation
    include_dirs:
      - src
      - sim
    files:
      - sim/tb_or_ctrl.sv
